//--- memPkg.sv
//************************************************************
// sizes, command enums and port structs of the scratchpad
//************************************************************
package memPkg;

  // array geometry
  localparam int unsigned NumWords  = 64;
  localparam int unsigned AddrWidth = $clog2(NumWords);
  localparam int unsigned DataWidth = 32;
  localparam int unsigned ByteWidth = 8;
  localparam int unsigned BeWidth   = DataWidth / ByteWidth;
  // one extra bit so a full-array burst of 64 fits
  localparam int unsigned LenWidth  = AddrWidth + 1;
  // edges from read request to data at the macro output
  localparam int unsigned RdLatency = 2;

  // write engine opcodes
  typedef enum logic {
    OpSeek  = 1'b0,
    OpWrite = 1'b1
  } wrOp_e;

  // burst reader states
  typedef enum logic {
    RdIdle  = 1'b0,
    RdBurst = 1'b1
  } rdState_e;

  // write command from outside, 44 bits
  typedef struct packed {
    logic                 valid;
    wrOp_e                op;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] data;
    logic [BeWidth-1:0]   be;
  } wrCmd_t;

  // single SRAM port request, 44 bits
  typedef struct packed {
    logic                 req;
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic [BeWidth-1:0]   be;
  } memReq_t;

  // burst start command, 14 bits
  typedef struct packed {
    logic                 start;
    logic [AddrWidth-1:0] base;
    logic [LenWidth-1:0]  len;
  } rdCmd_t;

  // streamed read response, 34 bits
  typedef struct packed {
    logic                 valid;
    logic                 last;
    logic [DataWidth-1:0] data;
  } rdResp_t;

endpackage

//--- wrEngine.sv
//************************************************************
// write engine: seek/write decode and port-0 request register
//************************************************************
`timescale 1ns/1ps

module wrEngine (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  memPkg::wrCmd_t wrCmd_i,
  output memPkg::memReq_t wrReq_o
);

  // write pointer, wraps with the address width
  logic [memPkg::AddrWidth-1:0] wrPtrQ;
  // request control bit
  logic                         reqQ;
  // request payload
  logic [memPkg::AddrWidth-1:0] addrQ;
  logic [memPkg::DataWidth-1:0] wdataQ;
  logic [memPkg::BeWidth-1:0]   beQ;

  logic isWrite;
  logic isSeek;

  // command decode
  assign isWrite = wrCmd_i.valid && (wrCmd_i.op == memPkg::OpWrite);
  assign isSeek  = wrCmd_i.valid && (wrCmd_i.op == memPkg::OpSeek);

  // pointer and request strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wrPtrQ <= '0;
      reqQ   <= 1'b0;
    end else begin
      // one registered request per write command
      reqQ <= isWrite;
      if (isSeek) begin
        wrPtrQ <= wrCmd_i.addr;
      end else if (isWrite) begin
        // natural wrap modulo NumWords
        wrPtrQ <= wrPtrQ + 1'b1;
      end
    end
  end

  // payload follows the write command, addressed at the current pointer
  always_ff @(posedge clk_i) begin
    if (isWrite) begin
      addrQ  <= wrPtrQ;
      wdataQ <= wrCmd_i.data;
      beQ    <= wrCmd_i.be;
    end
  end

  // port 0 only ever writes
  always_comb begin
    wrReq_o.req   = reqQ;
    wrReq_o.we    = reqQ;
    wrReq_o.addr  = addrQ;
    wrReq_o.wdata = wdataQ;
    wrReq_o.be    = beQ;
  end

endmodule

//--- sramMacro.sv
//************************************************************
// two-port byte-enable SRAM model with fixed read latency
//************************************************************
`timescale 1ns/1ps

module sramMacro (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  memPkg::memReq_t              wrReq_i,
  input  memPkg::memReq_t              rdReq_i,
  output logic [memPkg::DataWidth-1:0] rdData_o
);

  // word array
  logic [memPkg::DataWidth-1:0] mem [memPkg::NumWords];
  // held read address of port 1, the only port that reads here
  logic [memPkg::AddrWidth-1:0] rdAddrQ;
  // read data pipeline, index 0 drives the output
  logic [memPkg::DataWidth-1:0] rdPipeQ [memPkg::RdLatency];
  logic [memPkg::DataWidth-1:0] rdWord;
  logic                         rdHit;
  logic                         wr0;
  logic                         wr1;

  // simulation starts from an all-zero array
  initial begin
    for (int i = 0; i < memPkg::NumWords; i++) begin
      mem[i] = '0;
    end
  end

  assign rdHit = rdReq_i.req && !rdReq_i.we;
  assign wr0   = wrReq_i.req && wrReq_i.we;
  assign wr1   = rdReq_i.req && rdReq_i.we;

  // new address on a read, else the last read address
  assign rdWord = rdHit ? mem[rdReq_i.addr] : mem[rdAddrQ];

  // remember read address for idle cycles
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdAddrQ <= '0;
    end else if (rdHit) begin
      rdAddrQ <= rdReq_i.addr;
    end
  end

  // pipeline samples the array before this edge's writes land
  always_ff @(posedge clk_i) begin
    rdPipeQ[memPkg::RdLatency-1] <= rdWord;
    for (int s = 0; s < memPkg::RdLatency - 1; s++) begin
      rdPipeQ[s] <= rdPipeQ[s+1];
    end
  end

  assign rdData_o = rdPipeQ[0];

  // byte-enable writes
  // port 1 comes second, so it wins on equal addresses
  always_ff @(posedge clk_i) begin
    if (wr0) begin
      for (int b = 0; b < memPkg::BeWidth; b++) begin
        if (wrReq_i.be[b]) begin
          mem[wrReq_i.addr][b*memPkg::ByteWidth +: memPkg::ByteWidth] <=
            wrReq_i.wdata[b*memPkg::ByteWidth +: memPkg::ByteWidth];
        end
      end
    end
    if (wr1) begin
      for (int b = 0; b < memPkg::BeWidth; b++) begin
        if (rdReq_i.be[b]) begin
          mem[rdReq_i.addr][b*memPkg::ByteWidth +: memPkg::ByteWidth] <=
            rdReq_i.wdata[b*memPkg::ByteWidth +: memPkg::ByteWidth];
        end
      end
    end
  end

endmodule

//--- rdEngine.sv
//************************************************************
// burst reader: port-1 read FSM and aligned valid/last flags
//************************************************************
`timescale 1ns/1ps

module rdEngine (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  memPkg::rdCmd_t               rdCmd_i,
  output memPkg::memReq_t              rdReq_o,
  input  logic [memPkg::DataWidth-1:0] rdData_i,
  output memPkg::rdResp_t              rdResp_o,
  output logic                         busy_o
);

  memPkg::rdState_e stateQ;
  memPkg::rdState_e stateD;
  // next read address, wraps with the address width
  logic [memPkg::AddrWidth-1:0] addrQ;
  logic [memPkg::AddrWidth-1:0] addrD;
  // reads still to issue
  logic [memPkg::LenWidth-1:0]  cntQ;
  logic [memPkg::LenWidth-1:0]  cntD;
  // flag shift registers, same depth as the SRAM read pipeline
  logic [memPkg::RdLatency-1:0] vldQ;
  logic [memPkg::RdLatency-1:0] lastQ;

  logic reqVld;
  logic reqLast;

  // one request per cycle while bursting
  assign reqVld  = (stateQ == memPkg::RdBurst);
  assign reqLast = reqVld && (cntQ == memPkg::LenWidth'(1));
  assign busy_o  = reqVld;

  always_comb begin
    stateD = stateQ;
    addrD  = addrQ;
    cntD   = cntQ;
    unique case (stateQ)
      memPkg::RdIdle: begin
        if (rdCmd_i.start) begin
          stateD = memPkg::RdBurst;
          addrD  = rdCmd_i.base;
          // zero length means the full array, 2**AddrWidth words
          if (rdCmd_i.len == '0) begin
            cntD = {1'b1, {memPkg::AddrWidth{1'b0}}};
          end else begin
            cntD = rdCmd_i.len;
          end
        end
      end
      memPkg::RdBurst: begin
        // starts are ignored here
        addrD = addrQ + 1'b1;
        cntD  = cntQ - 1'b1;
        if (reqLast) begin
          stateD = memPkg::RdIdle;
        end
      end
      default: stateD = memPkg::RdIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stateQ <= memPkg::RdIdle;
      cntQ   <= '0;
      vldQ   <= '0;
      lastQ  <= '0;
    end else begin
      stateQ <= stateD;
      cntQ   <= cntD;
      // flags enter at the top, leave at index 0 with the data
      vldQ   <= {reqVld, vldQ[memPkg::RdLatency-1:1]};
      lastQ  <= {reqLast, lastQ[memPkg::RdLatency-1:1]};
    end
  end

  // address is payload, only meaningful while bursting
  always_ff @(posedge clk_i) begin
    addrQ <= addrD;
  end

  // read-only use of port 1
  always_comb begin
    rdReq_o.req   = reqVld;
    rdReq_o.we    = 1'b0;
    rdReq_o.addr  = addrQ;
    rdReq_o.wdata = '0;
    rdReq_o.be    = '0;
  end

  always_comb begin
    rdResp_o.valid = vldQ[0];
    rdResp_o.last  = lastQ[0];
    rdResp_o.data  = rdData_i;
  end

endmodule

//--- scratchpadTop.sv
//************************************************************
// scratchpad top: write engine, SRAM macro, burst reader
//************************************************************
`timescale 1ns/1ps

module scratchpadTop (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  memPkg::wrCmd_t  wrCmd_i,
  input  memPkg::rdCmd_t  rdCmd_i,
  output memPkg::rdResp_t rdResp_o,
  output logic            busy_o
);

  // port 0, writes only
  memPkg::memReq_t              wrReq;
  // port 1, reads only
  memPkg::memReq_t              rdReq;
  // port 1 read data back to the reader
  logic [memPkg::DataWidth-1:0] rdData;

  // producer
  wrEngine u_wrEngine (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wrCmd_i (wrCmd_i),
    .wrReq_o (wrReq)
  );

  // shared array
  sramMacro u_sramMacro (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wrReq_i  (wrReq),
    .rdReq_i  (rdReq),
    .rdData_o (rdData)
  );

  // consumer
  rdEngine u_rdEngine (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .rdCmd_i  (rdCmd_i),
    .rdReq_o  (rdReq),
    .rdData_i (rdData),
    .rdResp_o (rdResp_o),
    .busy_o   (busy_o)
  );

endmodule

//--- scratchpadTop_sva.sv
//************************************************************
// bound assertions on the scratchpad top-level strobes
//************************************************************
`timescale 1ns/1ps

module scratchpadTopSva (
  input logic            clk_i,
  input logic            rst_ni,
  input memPkg::rdCmd_t  rdCmd_i,
  input memPkg::rdResp_t rdResp_i,
  input logic            busy_i
);

  // last only ever marks a valid beat
  lastNeedsValid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rdResp_i.last |-> rdResp_i.valid)
    else $error("rdResp last seen without valid");

  // outputs stay quiet while reset is held
  quietInReset: assert property (@(posedge clk_i)
    !rst_ni |-> (!busy_i && !rdResp_i.valid && !rdResp_i.last))
    else $error("busy or valid raised during reset");

  // a start taken while idle shows as busy one cycle later
  startRaisesBusy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rdCmd_i.start && !busy_i) |=> busy_i)
    else $error("accepted start did not raise busy");

endmodule

bind scratchpadTop scratchpadTopSva u_scratchpadTopSva (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .rdCmd_i  (rdCmd_i),
  .rdResp_i (rdResp_o),
  .busy_i   (busy_o)
);

//--- scratchpadTb.sv
//************************************************************
// LFSR stimulus, reference model, response comparator,
// watchdog and report for the scratchpad
//************************************************************
`timescale 1ns/1ps

module scratchpadTb;

  localparam int unsigned RandIters  = 24;
  // rough cycle cost of each test with the random loop at worst case per step
  localparam int unsigned TestCycles = 8 + 80 + 150 + 150 + 40 + 40 + RandIters * 80 + 80;
  localparam int unsigned Margin     = 200;

  logic            clk;
  logic            rstN;
  memPkg::wrCmd_t  wrCmd;
  memPkg::rdCmd_t  rdCmd;
  memPkg::rdResp_t rdResp;
  logic            busy;

  // reference array and pointer
  logic [memPkg::DataWidth-1:0] refMem [memPkg::NumWords];
  logic [memPkg::AddrWidth-1:0] refPtr;
  // words and last flags still owed by the DUT
  logic [memPkg::DataWidth-1:0] expData [$];
  logic                         expLast [$];
  logic [15:0]                  lfsr;
  int                           passCnt;
  int                           failCnt;
  int                           testFailBase;

  scratchpadTop u_scratchpadTop (
    .clk_i    (clk),
    .rst_ni   (rstN),
    .wrCmd_i  (wrCmd),
    .rdCmd_i  (rdCmd),
    .rdResp_o (rdResp),
    .busy_o   (busy)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // galois step with taps for x^16+x^14+x^13+x^11+1
  function automatic logic [15:0] nextLfsr(logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] takeBits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = nextLfsr(lfsr);
    end
    return v;
  endfunction

  // seek loads the pointer and write merges enabled bytes then steps
  function automatic void applyWrite(memPkg::wrCmd_t cmd);
    if (cmd.op == memPkg::OpSeek) begin
      refPtr = cmd.addr;
    end else begin
      for (int b = 0; b < memPkg::BeWidth; b++) begin
        if (cmd.be[b]) begin
          refMem[refPtr][b*memPkg::ByteWidth +: memPkg::ByteWidth] =
            cmd.data[b*memPkg::ByteWidth +: memPkg::ByteWidth];
        end
      end
      refPtr = refPtr + 1'b1;
    end
  endfunction

  // expected word at an address that wraps past the top
  function automatic logic [memPkg::DataWidth-1:0] expectedWord(int addr);
    return refMem[addr % memPkg::NumWords];
  endfunction

  task automatic sendCmd(memPkg::wrOp_e op, logic [memPkg::AddrWidth-1:0] addr,
                         logic [memPkg::DataWidth-1:0] data, logic [memPkg::BeWidth-1:0] be);
    memPkg::wrCmd_t cmd;
    cmd.valid = 1'b1;
    cmd.op    = op;
    cmd.addr  = addr;
    cmd.data  = data;
    cmd.be    = be;
    applyWrite(cmd);
    wrCmd = cmd;
    @(posedge clk);
    #1;
    wrCmd = '0;
  endtask

  // push expectations only when the DUT is meant to take the start
  task automatic issueStart(logic [memPkg::AddrWidth-1:0] base,
                            logic [memPkg::LenWidth-1:0] len, bit accepted);
    int n;
    n = (len == '0) ? memPkg::NumWords : int'(len);
    if (accepted) begin
      for (int i = 0; i < n; i++) begin
        expData.push_back(expectedWord(int'(base) + i));
        expLast.push_back(i == n - 1);
      end
    end
    rdCmd.start = 1'b1;
    rdCmd.base  = base;
    rdCmd.len   = len;
    @(posedge clk);
    #1;
    rdCmd = '0;
  endtask

  task automatic waitIdle();
    while (busy) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic waitDrained();
    while (busy || expData.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic checkLow(logic v, string what);
    assert (v == 1'b0) begin
      passCnt++;
    end else begin
      $display("ERROR @%0t: %s expected 0, got %b", $time, what, v);
      failCnt++;
    end
  endtask

  task automatic endTest(int num, string name);
    waitDrained();
    if (failCnt == testFailBase) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, failCnt - testFailBase);
    end
    testFailBase = failCnt;
  endtask

  // compare on the falling edge where the response is settled
  always @(negedge clk) begin
    logic [memPkg::DataWidth-1:0] want;
    logic                         wantLast;
    if (rstN && rdResp.valid) begin
      if (expData.size() == 0) begin
        $display("unexpected response at %0t with no burst pending", $time);
        failCnt++;
      end else begin
        want     = expData.pop_front();
        wantLast = expLast.pop_front();
        assert (rdResp.data == want) begin
          passCnt++;
        end else begin
          $display("ERROR @%0t: data expected %h, got %h", $time, want, rdResp.data);
          failCnt++;
        end
        assert (rdResp.last == wantLast) begin
          passCnt++;
        end else begin
          $display("ERROR @%0t: last expected %b, got %b", $time, wantLast, rdResp.last);
          failCnt++;
        end
      end
    end
  end

  initial begin
    repeat (TestCycles + Margin) @(posedge clk);
    $display("simulation timed out after %0d cycles", TestCycles + Margin);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    logic [1:0] sel;
    lfsr         = 16'd49;
    passCnt      = 0;
    failCnt      = 0;
    testFailBase = 0;
    refPtr       = '0;
    for (int i = 0; i < memPkg::NumWords; i++) begin
      refMem[i] = '0;
    end
    wrCmd = '0;
    rdCmd = '0;
    rstN  = 1'b1;
    // a clean falling edge starts the asynchronous reset
    #1;
    rstN  = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rstN = 1'b1;

    // idle outputs and a full-array burst of zeros
    checkLow(busy, "busy_o");
    checkLow(rdResp.valid, "rdResp_o.valid");
    issueStart('0, '0, 1'b1);
    endTest(1, "reset and zero contents");

    sendCmd(memPkg::OpSeek, '0, '0, '0);
    repeat (memPkg::NumWords) sendCmd(memPkg::OpWrite, '0, takeBits(32), 4'hF);
    issueStart('0, memPkg::LenWidth'(memPkg::NumWords), 1'b1);
    endTest(2, "sequential write and readback");

    // partial byte enables over the whole array
    sendCmd(memPkg::OpSeek, '0, '0, '0);
    repeat (memPkg::NumWords) begin
      sendCmd(memPkg::OpWrite, '0, takeBits(32), memPkg::BeWidth'(takeBits(4)));
    end
    issueStart('0, '0, 1'b1);
    endTest(3, "byte-enable merging");

    // pointer wraps from 63 to 0 and the burst crosses the top too
    sendCmd(memPkg::OpSeek, 6'd60, '0, '0);
    repeat (8) sendCmd(memPkg::OpWrite, '0, takeBits(32), 4'hF);
    issueStart(6'd58, 7'd12, 1'b1);
    endTest(4, "seek and wrap");

    // second start lands while busy and must vanish
    issueStart(6'd10, 7'd6, 1'b1);
    issueStart(6'd40, 7'd5, 1'b0);
    waitIdle();
    issueStart(6'd20, 7'd9, 1'b1);
    endTest(5, "back-to-back bursts and ignored start");

    for (int it = 0; it < RandIters; it++) begin
      sel = 2'(takeBits(2));
      case (sel)
        2'd0: sendCmd(memPkg::OpSeek, memPkg::AddrWidth'(takeBits(6)), '0, '0);
        2'd3: begin
          issueStart(memPkg::AddrWidth'(takeBits(6)), memPkg::LenWidth'(takeBits(6)), 1'b1);
          waitDrained();
        end
        default: begin
          repeat (takeBits(3) + 1) begin
            sendCmd(memPkg::OpWrite, '0, takeBits(32), memPkg::BeWidth'(takeBits(4)));
          end
        end
      endcase
    end
    issueStart('0, '0, 1'b1);
    endTest(6, "random mixed traffic");

    $display("checks passed %0d failed %0d", passCnt, failCnt);
    if (failCnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- filelist.f
memPkg.sv
wrEngine.sv
sramMacro.sv
rdEngine.sv
scratchpadTop.sv
scratchpadTop_sva.sv
scratchpadTb.sv

//--- Makefile
SRCS = $(shell cat filelist.f)

obj_dir/VscratchpadTb: filelist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module scratchpadTb -f filelist.f

run: obj_dir/VscratchpadTb
	@out=$$(./obj_dir/VscratchpadTb); echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

.PHONY: run clean
